/* src/tftGfxPkg.sv */
package tftGfxPkg;

    ////////////////////////////////////////////////////////////////////////////
    // Panel geometry and engine sizing
    ////////////////////////////////////////////////////////////////////////////

    localparam int SCREEN_W     = 480;                  // Visible columns.
    localparam int SCREEN_H     = 800;                  // Visible rows.
    localparam int NUM_LANES    = 2;                    // Raster lanes.
    localparam int LANE_DEPTH   = 2;                    // Command slots per lane.
    localparam int HOST_CREDITS = 2;                    // Host input buffer depth.
    localparam int RESET_CYCLES = 16;                   // Panel reset hold time.

    // Panel command codes, sent with rs low.
    localparam logic [15:0] CMD_SET_COL   = 16'h002A;   // Column address set.
    localparam logic [15:0] CMD_SET_ROW   = 16'h002B;   // Row address set.
    localparam logic [15:0] CMD_MEM_WRITE = 16'h002C;   // Start of pixel data.

    ////////////////////////////////////////////////////////////////////////////
    // Command and pixel types
    ////////////////////////////////////////////////////////////////////////////

    typedef enum logic [1:0] {
        OP_POINT,                                       // Single pixel.
        OP_HLINE,                                       // Row segment.
        OP_VLINE                                        // Column segment.
    } gfxOp_t;

    typedef struct packed {
        logic [15:0] x;
        logic [15:0] y;
        logic [15:0] color;                             // RGB565.
        logic [15:0] spare;                             // Unused by points.
    } pointView_t;

    typedef struct packed {
        logic [15:0] fixed;                             // Y of hline, x of vline.
        logic [15:0] start;                             // Either end first.
        logic [15:0] stop;
        logic [15:0] color;
    } spanView_t;

    typedef union packed {
        pointView_t pointView;
        spanView_t  spanView;
    } gfxPayload_t;

    typedef struct packed {
        gfxOp_t      op;
        gfxPayload_t payload;
    } gfxCmd_t;                                         // 66 bits.

    typedef struct packed {
        logic [15:0] x;
        logic [15:0] y;
        logic [15:0] color;
    } pixelWrite_t;                                     // 48 bits.

    typedef struct packed {
        logic        cs;                                // Active low.
        logic        rs;                                // Low on command words.
        logic        wr;                                // Latched on rising edge.
        logic        rd;                                // Held high.
        logic [15:0] data;
    } lcdBus_t;                                         // 20 bits.

endpackage

/* src/cmdDispatch.sv */
`timescale 1ns/1ps

module cmdDispatch import tftGfxPkg::*; (
    input  logic                 clk_20MHz,
    input  logic                 rst_n,
    input  logic                 cmdValid,
    input  gfxCmd_t              cmd,
    output logic                 cmdCredit,
    output logic [NUM_LANES-1:0] laneValid,
    output gfxCmd_t              laneCmd,
    input  logic [NUM_LANES-1:0] laneCredit
);

    typedef logic [$clog2(HOST_CREDITS)-1:0]   hostPtr_t;
    typedef logic [$clog2(HOST_CREDITS+1)-1:0] hostCnt_t;
    typedef logic [$clog2(LANE_DEPTH+1)-1:0]   laneCnt_t;

    gfxCmd_t              fifoMem [HOST_CREDITS];       // Host command buffer.
    hostPtr_t             wrPtr;
    hostPtr_t             rdPtr;
    hostCnt_t             fifoCount;
    laneCnt_t             laneCnt [NUM_LANES];          // Free slots per lane.
    logic [NUM_LANES-1:0] issueSel;                     // One-hot target lane.
    logic                 popEn;

    // Lowest lane with a free slot wins.
    always_comb begin
        issueSel = '0;
        for (int i = NUM_LANES - 1; i >= 0; i--) begin
            if (laneCnt[i] != '0) begin
                issueSel    = '0;
                issueSel[i] = 1'b1;
            end
        end
    end

    assign popEn     = (fifoCount != '0) && (|issueSel);
    assign laneValid = popEn ? issueSel : '0;           // Head goes out this cycle.
    assign laneCmd   = fifoMem[rdPtr];
    assign cmdCredit = popEn;                           // Slot freed for the host.

    always_ff @(posedge clk_20MHz) begin
        if (cmdValid) begin
            fifoMem[wrPtr] <= cmd;                      // Host only sends on credit.
        end
    end

    always_ff @(posedge clk_20MHz or negedge rst_n) begin
        if (!rst_n) begin
            wrPtr     <= '0;
            rdPtr     <= '0;
            fifoCount <= '0;
            for (int i = 0; i < NUM_LANES; i++) begin
                laneCnt[i] <= laneCnt_t'(LANE_DEPTH);   // Every lane starts empty.
            end
        end else begin
            if (cmdValid) begin
                wrPtr <= (wrPtr == hostPtr_t'(HOST_CREDITS - 1)) ? '0 : wrPtr + 1'b1;
            end
            if (popEn) begin
                rdPtr <= (rdPtr == hostPtr_t'(HOST_CREDITS - 1)) ? '0 : rdPtr + 1'b1;
            end
            case ({cmdValid, popEn})
                2'b10:   fifoCount <= fifoCount + 1'b1;
                2'b01:   fifoCount <= fifoCount - 1'b1;
                default: fifoCount <= fifoCount;
            endcase
            for (int i = 0; i < NUM_LANES; i++) begin
                case ({laneCredit[i], laneValid[i]})
                    2'b10:   laneCnt[i] <= laneCnt[i] + 1'b1; // Lane started a command.
                    2'b01:   laneCnt[i] <= laneCnt[i] - 1'b1; // Slot taken.
                    default: laneCnt[i] <= laneCnt[i];
                endcase
            end
        end
    end

    // Lane credit bookkeeping holds against the lanes' own queues.
    for (genvar g = 0; g < NUM_LANES; g++) begin : genLaneChk
        assert property (@(posedge clk_20MHz) disable iff (!rst_n)
            laneValid[g] |-> laneCnt[g] != '0);
        assert property (@(posedge clk_20MHz) disable iff (!rst_n)
            laneCnt[g] <= laneCnt_t'(LANE_DEPTH));
    end

endmodule

/* src/rasterLane.sv */
`timescale 1ns/1ps

module rasterLane import tftGfxPkg::*; (
    input  logic        clk_20MHz,
    input  logic        rst_n,
    input  logic        cmdValid,
    input  gfxCmd_t     cmd,
    output logic        cmdCredit,
    output logic        pixValid,
    output pixelWrite_t pixel,
    input  logic        pixCredit
);

    typedef logic [$clog2(LANE_DEPTH)-1:0]   slotPtr_t;
    typedef logic [$clog2(LANE_DEPTH+1)-1:0] slotCnt_t;

    gfxCmd_t     queue [LANE_DEPTH];                    // Pending commands.
    slotPtr_t    wrPtr;
    slotPtr_t    rdPtr;
    slotCnt_t    qCount;
    gfxCmd_t     head;
    logic        busy;                                  // Walker has a command.
    logic        vert;                                  // Walking along y.
    logic        haveCredit;                            // Writer slot free.
    logic [15:0] pos;                                   // Moving coordinate.
    logic [15:0] last;                                  // Inclusive end.
    logic [15:0] fixed;                                 // Other coordinate.
    logic [15:0] color;
    logic [15:0] loPos;
    logic [15:0] hiPos;
    logic        onScreen;
    logic        step;
    logic        lastStep;
    logic        popEn;

    assign head = queue[rdPtr];

    // Span ends may arrive in either order.
    always_comb begin
        if (head.payload.spanView.start <= head.payload.spanView.stop) begin
            loPos = head.payload.spanView.start;
            hiPos = head.payload.spanView.stop;
        end else begin
            loPos = head.payload.spanView.stop;
            hiPos = head.payload.spanView.start;
        end
    end

    assign pixel.x     = vert ? fixed : pos;
    assign pixel.y     = vert ? pos : fixed;
    assign pixel.color = color;
    assign onScreen    = (pixel.x < 16'(SCREEN_W)) && (pixel.y < 16'(SCREEN_H));

    assign pixValid  = busy && onScreen && haveCredit;
    assign step      = busy && (!onScreen || haveCredit); // Clipped ones skip free.
    assign lastStep  = step && (pos == last);
    assign popEn     = (qCount != '0) && (!busy || lastStep);
    assign cmdCredit = popEn;                           // Slot back to dispatcher.

    ////////////////////////////////////////////////////////////////////////////
    // Queue and walker datapath
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk_20MHz) begin
        if (cmdValid) begin
            queue[wrPtr] <= cmd;
        end
        if (popEn) begin
            case (head.op)
                OP_HLINE, OP_VLINE: begin
                    pos   <= loPos;
                    last  <= hiPos;
                    fixed <= head.payload.spanView.fixed;
                    color <= head.payload.spanView.color;
                    vert  <= (head.op == OP_VLINE);
                end
                default: begin                          // A point is a one-pixel hline.
                    pos   <= head.payload.pointView.x;
                    last  <= head.payload.pointView.x;
                    fixed <= head.payload.pointView.y;
                    color <= head.payload.pointView.color;
                    vert  <= 1'b0;
                end
            endcase
        end else if (step) begin
            pos <= pos + 1'b1;
        end
    end

    always_ff @(posedge clk_20MHz or negedge rst_n) begin
        if (!rst_n) begin
            wrPtr      <= '0;
            rdPtr      <= '0;
            qCount     <= '0;
            busy       <= 1'b0;
            haveCredit <= 1'b1;                         // One holding slot in the writer.
        end else begin
            if (cmdValid) begin
                wrPtr <= (wrPtr == slotPtr_t'(LANE_DEPTH - 1)) ? '0 : wrPtr + 1'b1;
            end
            if (popEn) begin
                rdPtr <= (rdPtr == slotPtr_t'(LANE_DEPTH - 1)) ? '0 : rdPtr + 1'b1;
            end
            case ({cmdValid, popEn})
                2'b10:   qCount <= qCount + 1'b1;
                2'b01:   qCount <= qCount - 1'b1;
                default: qCount <= qCount;
            endcase
            if (popEn) begin
                busy <= 1'b1;
            end else if (lastStep) begin
                busy <= 1'b0;
            end
            haveCredit <= (haveCredit && !pixValid) || pixCredit;
        end
    end

    // Dispatcher never overfills, and one pixel waits for each returned credit.
    assert property (@(posedge clk_20MHz) disable iff (!rst_n)
        cmdValid |-> qCount < slotCnt_t'(LANE_DEPTH));
    assert property (@(posedge clk_20MHz) disable iff (!rst_n)
        pixValid && !pixCredit |=> !pixValid);

endmodule

/* src/lcdBusWriter.sv */
`timescale 1ns/1ps

module lcdBusWriter import tftGfxPkg::*; (
    input  logic                 clk_20MHz,
    input  logic                 rst_n,
    input  logic [NUM_LANES-1:0] pixValid,
    input  pixelWrite_t          pixel [NUM_LANES],
    output logic [NUM_LANES-1:0] pixCredit,
    output lcdBus_t              lcdBus,
    output logic                 lcdRst,
    output logic                 backlight
);

    typedef logic [$clog2(NUM_LANES)-1:0]    laneIdx_t;
    typedef logic [$clog2(RESET_CYCLES)-1:0] rstCnt_t;

    rstCnt_t              rstCnt;                       // Panel reset timer.
    logic                 panelUp;                      // Reset released.
    pixelWrite_t          hold [NUM_LANES];             // One pixel per lane.
    logic [NUM_LANES-1:0] holdValid;
    laneIdx_t             rrLast;                       // Lane served last.
    laneIdx_t             grantIdx;
    logic                 grantValid;
    logic                 busy;                         // Six-word group running.
    logic                 phase;                        // 0 wr low, 1 wr high.
    logic [2:0]           wordIdx;
    pixelWrite_t          cur;                          // Pixel on the bus.

    assign lcdRst    = panelUp;
    assign backlight = panelUp;                         // Lit with the panel.

    // Round-robin starting after the last served lane.
    always_comb begin
        int idx;
        grantValid = 1'b0;
        grantIdx   = rrLast;
        for (int k = NUM_LANES; k >= 1; k--) begin
            idx = (int'(rrLast) + k) % NUM_LANES;
            if (holdValid[idx]) begin
                grantValid = 1'b1;
                grantIdx   = laneIdx_t'(idx);
            end
        end
        if (busy || !panelUp) begin
            grantValid = 1'b0;                          // Bus occupied or panel in reset.
        end
    end

    always_comb begin
        for (int i = 0; i < NUM_LANES; i++) begin
            pixCredit[i] = grantValid && (grantIdx == laneIdx_t'(i));
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Word sequencer: col cmd, x, row cmd, y, write cmd, color
    ////////////////////////////////////////////////////////////////////////////

    always_comb begin
        lcdBus.cs = !busy;                              // Low for all 12 cycles.
        lcdBus.rs = wordIdx[0];                         // Odd words carry data.
        lcdBus.wr = !(busy && !phase);
        lcdBus.rd = 1'b1;
        case (wordIdx)
            3'd0:    lcdBus.data = CMD_SET_COL;
            3'd1:    lcdBus.data = cur.x;
            3'd2:    lcdBus.data = CMD_SET_ROW;
            3'd3:    lcdBus.data = cur.y;
            3'd4:    lcdBus.data = CMD_MEM_WRITE;
            3'd5:    lcdBus.data = cur.color;
            default: lcdBus.data = 16'h0000;            // Idle.
        endcase
    end

    always_ff @(posedge clk_20MHz) begin
        for (int i = 0; i < NUM_LANES; i++) begin
            if (pixValid[i]) begin
                hold[i] <= pixel[i];
            end
        end
        if (grantValid) begin
            cur <= hold[grantIdx];
        end
    end

    always_ff @(posedge clk_20MHz or negedge rst_n) begin
        if (!rst_n) begin
            rstCnt    <= '0;
            panelUp   <= 1'b0;
            holdValid <= '0;
            rrLast    <= '0;
            busy      <= 1'b0;
            phase     <= 1'b0;
            wordIdx   <= '0;
        end else begin
            if (!panelUp) begin
                rstCnt <= rstCnt + 1'b1;
                if (rstCnt == rstCnt_t'(RESET_CYCLES - 1)) begin
                    panelUp <= 1'b1;
                end
            end
            for (int i = 0; i < NUM_LANES; i++) begin
                if (pixValid[i]) begin
                    holdValid[i] <= 1'b1;
                end else if (pixCredit[i]) begin
                    holdValid[i] <= 1'b0;               // Moved into the sequencer.
                end
            end
            if (grantValid) begin
                busy    <= 1'b1;
                rrLast  <= grantIdx;
                wordIdx <= '0;
                phase   <= 1'b0;
            end else if (busy) begin
                phase <= !phase;
                if (phase) begin
                    wordIdx <= wordIdx + 1'b1;
                    if (wordIdx == 3'd5) begin
                        busy <= 1'b0;                   // cs rises for at least a cycle.
                    end
                end
            end
        end
    end

    assert property (@(posedge clk_20MHz) disable iff (!rst_n)
        !lcdBus.wr |-> !lcdBus.cs && lcdRst);

endmodule

/* src/tftGfxTop.sv */
`timescale 1ns/1ps

module tftGfxTop import tftGfxPkg::*; (
    input  logic    clk_20MHz,
    input  logic    rst_n,
    input  logic    cmdValid,
    input  gfxCmd_t cmd,
    output logic    cmdCredit,
    output lcdBus_t lcdBus,
    output logic    lcdRst,
    output logic    backlight
);

    logic [NUM_LANES-1:0] laneValid;                    // Dispatcher to lanes.
    logic [NUM_LANES-1:0] laneCredit;
    gfxCmd_t              laneCmd;                      // Shared by all lanes.
    logic [NUM_LANES-1:0] pixValid;                     // Lanes to writer.
    logic [NUM_LANES-1:0] pixCredit;
    pixelWrite_t          pixel [NUM_LANES];

    cmdDispatch dispatch0 (
        .clk_20MHz  (clk_20MHz),
        .rst_n      (rst_n),
        .cmdValid   (cmdValid),
        .cmd        (cmd),
        .cmdCredit  (cmdCredit),
        .laneValid  (laneValid),
        .laneCmd    (laneCmd),
        .laneCredit (laneCredit)
    );

    for (genvar g = 0; g < NUM_LANES; g++) begin : genLane
        rasterLane lane (
            .clk_20MHz (clk_20MHz),
            .rst_n     (rst_n),
            .cmdValid  (laneValid[g]),
            .cmd       (laneCmd),
            .cmdCredit (laneCredit[g]),
            .pixValid  (pixValid[g]),
            .pixel     (pixel[g]),
            .pixCredit (pixCredit[g])
        );
    end

    lcdBusWriter writer0 (
        .clk_20MHz (clk_20MHz),
        .rst_n     (rst_n),
        .pixValid  (pixValid),
        .pixel     (pixel),
        .pixCredit (pixCredit),
        .lcdBus    (lcdBus),
        .lcdRst    (lcdRst),
        .backlight (backlight)
    );

endmodule

/* bench/tftGfxTb.sv */
`timescale 1ns/1ps

module tftGfxTb import tftGfxPkg::*; ();

    localparam int PAT_DEPTH  = 64;                     // Pattern rows.
    localparam int HALF_CYCLE = 25;                     // 50 ns period.

    logic        clk_20MHz;
    logic        rst_n;
    logic        cmdValid;
    gfxCmd_t     cmd;
    logic        cmdCredit;
    lcdBus_t     lcdBus;
    logic        lcdRst;
    logic        backlight;

    logic [71:0] patMem [PAT_DEPTH];                    // Tag, op, payload.
    int          sb [logic [47:0]];                     // Keyed {x, y, color}.
    int          hostCredits;
    int          creditPulses;
    int          cmdsSent;
    int          rxCount;                               // Pixels seen on the bus.
    int          expTotal;
    int          cmdTotal;
    int          watchCycles;
    logic [31:0] lcgState;
    int          wordNum;                               // Word within a pixel.
    logic        prevWr;
    logic        csSeenHigh;
    logic [15:0] rxX;
    logic [15:0] rxY;

    tftGfxTop dut0 (
        .clk_20MHz (clk_20MHz),
        .rst_n     (rst_n),
        .cmdValid  (cmdValid),
        .cmd       (cmd),
        .cmdCredit (cmdCredit),
        .lcdBus    (lcdBus),
        .lcdRst    (lcdRst),
        .backlight (backlight)
    );

    initial begin
        clk_20MHz = 1'b0;
        forever #HALF_CYCLE clk_20MHz = ~clk_20MHz;
    end

    task automatic failRun(input string why);
        $display("%s", why);
        $display("Checks failed");
        $fatal(1);
    endtask

    task automatic checkValue(input string name, input logic [15:0] got, input logic [15:0] want);
        assert (got === want) else failRun($sformatf("Mismatch at %0t: %s got %h, expected %h",
            $time, name, got, want));
    endtask

    function automatic logic [31:0] nextRand();
        lcgState = lcgState * 32'd1664525 + 32'd1013904223;
        return lcgState;
    endfunction

    ////////////////////////////////////////////////////////////////////////////
    // Reference model with inclusive spans and screen clipping
    ////////////////////////////////////////////////////////////////////////////

    task automatic addPixel(input int x, input int y, input logic [15:0] color, inout int count);
        logic [47:0] key;
        if (x < SCREEN_W && y < SCREEN_H) begin
            key     = {16'(x), 16'(y), color};
            sb[key] = sb.exists(key) ? sb[key] + 1 : 1;
            count++;
        end
    endtask

    task automatic addCommand(input gfxCmd_t c, inout int count);
        int lo;
        int hi;
        lo = int'(c.payload.spanView.start);
        hi = int'(c.payload.spanView.stop);
        if (lo > hi) begin                              // Reversed ends.
            lo = int'(c.payload.spanView.stop);
            hi = int'(c.payload.spanView.start);
        end
        case (c.op)
            OP_POINT: addPixel(int'(c.payload.pointView.x), int'(c.payload.pointView.y),
                c.payload.pointView.color, count);
            OP_HLINE: for (int v = lo; v <= hi; v++) begin
                addPixel(v, int'(c.payload.spanView.fixed), c.payload.spanView.color, count);
            end
            OP_VLINE: for (int v = lo; v <= hi; v++) begin
                addPixel(int'(c.payload.spanView.fixed), v, c.payload.spanView.color, count);
            end
            default: failRun("Pattern file holds an unknown opcode");
        endcase
    endtask

    // Bus monitor runs once per falling edge. A wr rise shows as 0 then 1.
    task automatic sampleBus();
        logic [47:0] key;
        checkValue("lcdBus.rd", 16'(lcdBus.rd), 16'd1);
        if (!lcdBus.wr) begin
            assert (lcdRst && !lcdBus.cs) else failRun("Write strobe low with cs high or in reset");
        end
        if (lcdBus.cs) begin
            assert (wordNum == 0) else failRun("cs went high in the middle of a pixel");
            csSeenHigh = 1'b1;
        end
        if (!prevWr && lcdBus.wr) begin                 // Word latched by the panel.
            checkValue("lcdBus.rs", 16'(lcdBus.rs), 16'(wordNum % 2));
            case (wordNum)
                0: begin
                    assert (csSeenHigh) else failRun("No idle cs cycle between two pixels");
                    csSeenHigh = 1'b0;
                    checkValue("lcdBus.data", lcdBus.data, CMD_SET_COL);
                end
                1: rxX = lcdBus.data;
                2: checkValue("lcdBus.data", lcdBus.data, CMD_SET_ROW);
                3: rxY = lcdBus.data;
                4: checkValue("lcdBus.data", lcdBus.data, CMD_MEM_WRITE);
                default: begin
                    key = {rxX, rxY, lcdBus.data};
                    assert (int'(rxX) < SCREEN_W && int'(rxY) < SCREEN_H) else failRun(
                        $sformatf("Pixel at (%0d, %0d) lies off the screen", rxX, rxY));
                    assert (sb.exists(key)) else failRun($sformatf(
                        "Pixel at (%0d, %0d) color %h unexpected or repeated", rxX, rxY,
                        lcdBus.data));
                    sb[key] = sb[key] - 1;
                    if (sb[key] == 0) begin
                        sb.delete(key);
                    end
                    rxCount++;
                end
            endcase
            wordNum = (wordNum + 1) % 6;
        end
        prevWr = lcdBus.wr;
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // Host driver with its own credit count, stepped once per clock
    ////////////////////////////////////////////////////////////////////////////

    task automatic hostStep(input logic valid, input gfxCmd_t c);
        logic ret;
        sampleBus();
        ret      = cmdCredit;                           // Pulse seen at the coming edge.
        cmdValid = valid;
        cmd      = c;
        if (valid) begin
            hostCredits--;
            cmdsSent++;
        end
        assert (hostCredits >= 0) else failRun("Host sent a command without a credit");
        if (ret) begin
            hostCredits++;
            creditPulses++;
        end
        assert (hostCredits <= HOST_CREDITS) else failRun("More credits returned than taken");
        @(negedge clk_20MHz);
    endtask

    task automatic sendCommand(input gfxCmd_t c);
        int gap;
        gap = int'(nextRand() >> 29);                   // 0 to 7 idle cycles.
        repeat (gap) hostStep(1'b0, '0);
        while (hostCredits == 0) begin
            hostStep(1'b0, '0);
        end
        hostStep(1'b1, c);
    endtask

    initial begin
        logic [71:0] entry;
        int          endIdx;
        int          modelCount;
        int          doneTarget;
        cmdValid     = 1'b0;
        cmd          = '0;
        rst_n        = 1'b0;
        lcgState     = 32'h3ce6c1eb;
        hostCredits  = HOST_CREDITS;
        creditPulses = 0;
        cmdsSent     = 0;
        rxCount      = 0;
        expTotal     = 0;
        cmdTotal     = 0;
        watchCycles  = 0;
        wordNum      = 0;
        prevWr       = 1'b1;
        csSeenHigh   = 1'b1;
        rxX          = '0;
        rxY          = '0;
        endIdx       = PAT_DEPTH;
        modelCount   = 0;
        doneTarget   = 0;
        $readmemh("bench/tftPatterns.hex", patMem);
        for (int i = 0; i < PAT_DEPTH; i++) begin      // Totals for the watchdog.
            if (patMem[i][71:68] == 4'hF) begin
                endIdx = i;
                break;
            end
            case (patMem[i][71:68])
                4'h1:    cmdTotal++;
                4'h2:    expTotal += int'(patMem[i][15:0]);
                default: failRun($sformatf("Pattern row %0d has an unknown tag", i));
            endcase
        end
        assert (endIdx < PAT_DEPTH) else failRun("Pattern file has no end marker");
        watchCycles = 10 + RESET_CYCLES + 12 * expTotal + 200 * cmdTotal;

        repeat (10) @(negedge clk_20MHz);               // Ten cycles in reset.
        checkValue("lcdBus.cs", 16'(lcdBus.cs), 16'd1);
        checkValue("lcdBus.wr", 16'(lcdBus.wr), 16'd1);
        checkValue("lcdBus.rd", 16'(lcdBus.rd), 16'd1);
        checkValue("cmdCredit", 16'(cmdCredit), 16'd0);
        checkValue("lcdRst", 16'(lcdRst), 16'd0);
        checkValue("backlight", 16'(backlight), 16'd0);
        rst_n = 1'b1;
        for (int k = 1; k <= RESET_CYCLES; k++) begin  // Panel reset count-out.
            hostStep(1'b0, '0);
            checkValue("lcdRst", 16'(lcdRst), 16'(k == RESET_CYCLES));
            checkValue("backlight", 16'(backlight), 16'(k == RESET_CYCLES));
        end

        for (int i = 0; i < endIdx; i++) begin
            entry = patMem[i];
            if (entry[71:68] == 4'h1) begin
                addCommand(gfxCmd_t'(entry[65:0]), modelCount);
                sendCommand(gfxCmd_t'(entry[65:0]));
            end else begin                              // Group end drains the bus.
                checkValue("group pixel count", 16'(modelCount), entry[15:0]);
                doneTarget += modelCount;
                modelCount  = 0;
                while (rxCount < doneTarget) begin
                    hostStep(1'b0, '0);
                end
            end
        end
        repeat (50) hostStep(1'b0, '0);                 // Room for stray pixels and credits.
        assert (creditPulses == cmdsSent) else failRun($sformatf(
            "Host got %0d credit pulses back for %0d commands sent", creditPulses, cmdsSent));
        $display("All checks passed");
        $finish;
    end

    initial begin
        wait (watchCycles > 0);
        repeat (watchCycles) @(posedge clk_20MHz);
        failRun("Timeout before all expected pixels reached the panel bus");
    end

endmodule

/* bench/tftPatterns.hex */
// 18 hex digits per row: tag, op (0 point, 1 hline, 2 vline), four 16-bit fields.
// Tag 1 point x y color spare, line fixed start stop color; tag 2 pixel count; tag F end.

// Points, two of them off-screen.
10000A0014F8000000
1001DF031F07E00000
1000000000001F0000
1001E00005FFFF0000
1000050320FFFF0000
200000000000000003

// Horizontal lines, second one with reversed ends.
110064000A00131234
110065001E00152345
200000000000000014

// Vertical lines, second one with reversed ends.
1200C8012C01373456
1200C90154014B3457
200000000000000016

// Clipping at the right and bottom edges, and wholly off-screen.
11003201D601E94567
12003C031B03255678
1103200000000F6789
1201E00000000F789A
11031F01DF01D689AB
200000000000000019

// Load, six 16-pixel lines over both lanes.
11019000640073A001
11019100730064A002
12012C01F40203B001
12012D020301F4B002
11019200640073A003
12012E01F40203B003
200000000000000060

F00000000000000000

/* all.f */
src/tftGfxPkg.sv
src/cmdDispatch.sv
src/rasterLane.sv
src/lcdBusWriter.sv
src/tftGfxTop.sv
bench/tftGfxTb.sv

/* Makefile */
# Verilator build and run of the pixel engine testbench.

VERILATOR ?= verilator
TOP       ?= tftGfxTb
FILELIST  ?= all.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -j 0
PATTERNS  ?= bench/tftPatterns.hex

SOURCES   := $(filter-out +%,$(shell cat $(FILELIST)))
SIM       := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: $(SIM)

$(SIM): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(SIM) $(PATTERNS)
	./$(SIM)

clean:
	rm -rf $(OBJ_DIR)
